// ==== include/soc_bus_cfg.svh ====
`ifndef SOC_BUS_CFG_SVH
`define SOC_BUS_CFG_SVH

// Bus widths
`define SOC_ADDR_W     32
`define SOC_DATA_W     32

// On-chip RAM, word addressed behind a byte address
`define SOC_RAM_BYTES  1024
`define SOC_RAM_BASE   32'h0000_0000

// GPIO bank
`define SOC_GPIO_BASE  32'h1000_0000
`define SOC_GPIO_BYTES 16              // Four 32-bit registers
`define SOC_GPIO_W     8

`endif

// ==== verilog/soc_bus_pkg.sv ====
`default_nettype none

`include "soc_bus_cfg.svh"

package soc_bus_pkg;

  typedef logic [`SOC_ADDR_W-1:0]   wb_addr_t;   // Byte address
  typedef logic [`SOC_DATA_W-1:0]   wb_data_t;
  typedef logic [`SOC_DATA_W/8-1:0] wb_sel_t;    // One select per byte lane
  typedef logic [`SOC_GPIO_W-1:0]   gpio_t;

  typedef enum logic {M0_M, M1_M} wb_master_e;

  // NONE_S marks an unmapped address
  typedef enum logic [1:0] {RAM_S, GPIO_S, NONE_S} wb_slave_e;

  typedef enum logic [1:0] {ARB_IDLE, ARB_M0, ARB_M1} arb_state_e;

  typedef enum logic {RESP_ACK, RESP_ERR} wb_resp_e;

  // Register select from address bits 3:2
  typedef enum logic [1:0] {
    GPIO_OUT = 2'd0,
    GPIO_OE  = 2'd1,
    GPIO_IN  = 2'd2                    // Read-only
  } gpio_reg_e;

endpackage

`default_nettype wire

// ==== verilog/wb_if.sv ====
`default_nettype none

`include "soc_bus_cfg.svh"

// Pipelined Wishbone, one bus segment
interface wb_if;

  logic [`SOC_ADDR_W-1:0]   adr;
  logic [`SOC_DATA_W-1:0]   dat_m;     // Write data, master to slave
  logic [`SOC_DATA_W-1:0]   dat_s;     // Read data, slave to master
  logic [`SOC_DATA_W/8-1:0] sel;
  logic                     we;
  logic                     cyc;
  logic                     stb;
  logic                     stall;
  logic                     ack;
  logic                     err;

  modport master (
    output adr, dat_m, sel, we, cyc, stb,
    input  dat_s, stall, ack, err
  );

  modport slave (
    input  adr, dat_m, sel, we, cyc, stb,
    output dat_s, stall, ack, err
  );

  // Address decode only looks, never drives
  modport decode (input adr, cyc);

endinterface

`default_nettype wire

// ==== verilog/wb_arbiter.sv ====
`default_nettype none

// Two-master bus arbiter. The grant is registered and held for a whole
// Wishbone cycle; ties from idle alternate between the masters.
module wb_arbiter
  import soc_bus_pkg::*;
(
  input  wire logic sys_clk,
  input  wire logic rst_i,
  input  wire logic m0_cyc_i,
  input  wire logic m1_cyc_i,
  output arb_state_e grant_o
);

  arb_state_e state_q, state_d;
  wb_master_e last_q, last_d;     // Winner of the most recent grant

  always_comb begin
    state_d = state_q;
    last_d  = last_q;
    case (state_q)
      ARB_IDLE: begin
        if (m0_cyc_i && m1_cyc_i) begin
          // Tie goes to whoever did not win last time
          if (last_q == M0_M) begin
            state_d = ARB_M1;
            last_d  = M1_M;
          end else begin
            state_d = ARB_M0;
            last_d  = M0_M;
          end
        end else if (m0_cyc_i) begin
          state_d = ARB_M0;
          last_d  = M0_M;
        end else if (m1_cyc_i) begin
          state_d = ARB_M1;
          last_d  = M1_M;
        end
      end
      ARB_M0: if (!m0_cyc_i) state_d = ARB_IDLE;  // Release after cyc drops
      ARB_M1: if (!m1_cyc_i) state_d = ARB_IDLE;
      default: state_d = ARB_IDLE;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      state_q <= ARB_IDLE;
      last_q  <= M0_M;            // So M1 wins the first tie
    end else begin
      state_q <= state_d;
      last_q  <= last_d;
    end
  end

  assign grant_o = state_q;

endmodule

`default_nettype wire

// ==== verilog/wb_addr_decoder.sv ====
`default_nettype none

`include "soc_bus_cfg.svh"

// Address map lookup for both masters in parallel
module wb_addr_decoder
  import soc_bus_pkg::*;
(
  wb_if.decode      m0_dec,
  wb_if.decode      m1_dec,
  output wb_slave_e m0_slave_o,
  output wb_slave_e m1_slave_o
);

  localparam wb_addr_t RAM_BASE  = `SOC_RAM_BASE;
  localparam wb_addr_t RAM_SIZE  = `SOC_RAM_BYTES;
  localparam wb_addr_t GPIO_BASE = `SOC_GPIO_BASE;
  localparam wb_addr_t GPIO_SIZE = `SOC_GPIO_BYTES;

  function automatic logic in_window(wb_addr_t adr, wb_addr_t base, wb_addr_t size);
    return (adr >= base) && (adr < base + size);
  endfunction

  // No cycle means no target
  function automatic wb_slave_e lookup(logic cyc, wb_addr_t adr);
    if (!cyc) begin
      return NONE_S;
    end
    if (in_window(adr, RAM_BASE, RAM_SIZE)) begin
      return RAM_S;
    end
    if (in_window(adr, GPIO_BASE, GPIO_SIZE)) begin
      return GPIO_S;
    end
    return NONE_S;              // Unmapped, shared bus answers with err
  endfunction

  assign m0_slave_o = lookup(m0_dec.cyc, m0_dec.adr);
  assign m1_slave_o = lookup(m1_dec.cyc, m1_dec.adr);

endmodule

`default_nettype wire

// ==== verilog/wb_shared_bus.sv ====
`default_nettype none

// Shared bus: the granted master talks to its decoded slave, the other
// master waits under stall. Unmapped strobes get an err from here.
module wb_shared_bus
  import soc_bus_pkg::*;
(
  input  wire logic       sys_clk,
  input  wire logic       rst_i,
  input  wire arb_state_e grant_i,
  input  wire wb_slave_e  m0_slave_i,
  input  wire wb_slave_e  m1_slave_i,
  wb_if.slave             m0,
  wb_if.slave             m1,
  wb_if.master            ram,
  wb_if.master            gpio
);

  logic      m0_gnt, m1_gnt;
  logic      req_cyc, req_stb, req_we;
  wb_addr_t  req_adr;
  wb_data_t  req_dat;
  wb_sel_t   req_sel;
  wb_slave_e req_slave;
  logic      req_stall;
  logic      accept;

  logic      pend_q;            // A strobe was accepted last cycle
  wb_slave_e pend_slave_q;
  wb_resp_e  pend_resp_q;

  logic      rsp_ack, rsp_err;
  wb_data_t  rsp_dat;

  assign m0_gnt = (grant_i == ARB_M0);
  assign m1_gnt = (grant_i == ARB_M1);

  // Request side of the granted master
  assign req_cyc   = (m0_gnt & m0.cyc) | (m1_gnt & m1.cyc);
  assign req_stb   = (m0_gnt & m0.stb) | (m1_gnt & m1.stb);
  assign req_we    = m1_gnt ? m1.we    : m0.we;
  assign req_adr   = m1_gnt ? m1.adr   : m0.adr;
  assign req_dat   = m1_gnt ? m1.dat_m : m0.dat_m;
  assign req_sel   = m1_gnt ? m1.sel   : m0.sel;
  assign req_slave = m1_gnt ? m1_slave_i : m0_slave_i;

  always_comb begin
    case (req_slave)
      RAM_S:   req_stall = ram.stall;
      GPIO_S:  req_stall = gpio.stall;
      default: req_stall = 1'b0;     // Error path never stalls
    endcase
  end

  assign accept = req_cyc & req_stb & ~req_stall;

  // Slaves share cyc and payload, stb only reaches the decoded one
  assign ram.cyc    = req_cyc;
  assign ram.stb    = req_stb & (req_slave == RAM_S);
  assign ram.we     = req_we;
  assign ram.adr    = req_adr;
  assign ram.dat_m  = req_dat;
  assign ram.sel    = req_sel;
  assign gpio.cyc   = req_cyc;
  assign gpio.stb   = req_stb & (req_slave == GPIO_S);
  assign gpio.we    = req_we;
  assign gpio.adr   = req_adr;
  assign gpio.dat_m = req_dat;
  assign gpio.sel   = req_sel;

  always_ff @(posedge sys_clk) begin
    if (rst_i) pend_q <= 1'b0;
    else       pend_q <= accept;
  end

  // Remember where the in-flight strobe went
  always_ff @(posedge sys_clk) begin
    if (accept) begin
      pend_slave_q <= req_slave;
      pend_resp_q  <= (req_slave == NONE_S) ? RESP_ERR : RESP_ACK;
    end
  end

  assign rsp_ack = ram.ack | gpio.ack;
  assign rsp_err = ram.err | gpio.err | (pend_q && pend_resp_q == RESP_ERR);
  assign rsp_dat = (pend_slave_q == GPIO_S) ? gpio.dat_s : ram.dat_s;

  // Responses go back to the grant holder only
  assign m0.stall = ~m0_gnt | req_stall;
  assign m0.ack   = m0_gnt & rsp_ack;
  assign m0.err   = m0_gnt & rsp_err;
  assign m0.dat_s = m0_gnt ? rsp_dat : '0;
  assign m1.stall = ~m1_gnt | req_stall;
  assign m1.ack   = m1_gnt & rsp_ack;
  assign m1.err   = m1_gnt & rsp_err;
  assign m1.dat_s = m1_gnt ? rsp_dat : '0;

endmodule

`default_nettype wire

// ==== verilog/wb_ram_slave.sv ====
`default_nettype none

`include "soc_bus_cfg.svh"

// Single-port word RAM, byte lane writes, ack one cycle after accept
module wb_ram_slave
  import soc_bus_pkg::*;
#(
  parameter int DEPTH_WORDS = `SOC_RAM_BYTES / 4
) (
  input  wire logic sys_clk,
  input  wire logic rst_i,
  wb_if.slave       bus
);

  localparam int IDX_W = $clog2(DEPTH_WORDS);

  wb_data_t         mem [DEPTH_WORDS];
  wb_data_t         rdata_q;
  logic             ack_q;
  logic [IDX_W-1:0] word_idx;
  logic             accept;

  assign word_idx = bus.adr[IDX_W+1:2];      // Byte address to word index
  assign accept   = bus.cyc & bus.stb & ~bus.stall;

  always_ff @(posedge sys_clk) begin
    if (accept && bus.we) begin
      for (int b = 0; b < $bits(wb_sel_t); b++) begin
        if (bus.sel[b]) mem[word_idx][8*b +: 8] <= bus.dat_m[8*b +: 8];
      end
    end
    if (accept && !bus.we) rdata_q <= mem[word_idx];
  end

  always_ff @(posedge sys_clk) begin
    if (rst_i) ack_q <= 1'b0;
    else       ack_q <= accept;
  end

  assign bus.stall = 1'b0;                   // Always ready
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;
  assign bus.dat_s = rdata_q;

endmodule

`default_nettype wire

// ==== verilog/wb_gpio_slave.sv ====
`default_nettype none

`include "soc_bus_cfg.svh"

// GPIO bank: output and output-enable registers plus synchronized inputs
module wb_gpio_slave
  import soc_bus_pkg::*;
#(
  parameter int WIDTH = `SOC_GPIO_W
) (
  input  wire logic             sys_clk,
  input  wire logic             rst_i,
  wb_if.slave                   bus,
  input  wire logic [WIDTH-1:0] gpio_i,
  output logic      [WIDTH-1:0] gpio_o,
  output logic      [WIDTH-1:0] gpio_oe_o
);

  logic [WIDTH-1:0] out_q, oe_q;
  logic [WIDTH-1:0] sync1_q, sync2_q;
  gpio_reg_e        reg_sel;
  wb_data_t         rdata_q;
  logic             ack_q;
  logic             accept;

  assign reg_sel = gpio_reg_e'(bus.adr[3:2]);
  assign accept  = bus.cyc & bus.stb & ~bus.stall;

  always_ff @(posedge sys_clk) begin
    sync1_q <= gpio_i;            // Two-flop synchronizer
    sync2_q <= sync1_q;
  end

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      out_q <= '0;
      oe_q  <= '0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= accept;
      if (accept && bus.we && bus.sel[0]) begin
        case (reg_sel)
          GPIO_OUT: out_q <= bus.dat_m[WIDTH-1:0];
          GPIO_OE:  oe_q  <= bus.dat_m[WIDTH-1:0];
          default:  ;                       // GPIO_IN is read-only
        endcase
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (accept && !bus.we) begin
      case (reg_sel)
        GPIO_OUT: rdata_q <= wb_data_t'(out_q);
        GPIO_OE:  rdata_q <= wb_data_t'(oe_q);
        GPIO_IN:  rdata_q <= wb_data_t'(sync2_q);
        default:  rdata_q <= '0;
      endcase
    end
  end

  assign bus.stall = 1'b0;
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;
  assign bus.dat_s = rdata_q;
  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;

endmodule

`default_nettype wire

// ==== verilog/soc_fabric_top.sv ====
`default_nettype none

`include "soc_bus_cfg.svh"

// Wishbone fabric with two external masters, RAM and GPIO
module soc_fabric_top
  import soc_bus_pkg::*;
(
  input  wire logic     sys_clk,
  input  wire logic     rst_i,

  // Master 0
  input  wire logic     m0_cyc_i,
  input  wire logic     m0_stb_i,
  input  wire logic     m0_we_i,
  input  wire wb_addr_t m0_adr_i,
  input  wire wb_data_t m0_dat_i,
  input  wire wb_sel_t  m0_sel_i,
  output wb_data_t      m0_dat_o,
  output logic          m0_stall_o,
  output logic          m0_ack_o,
  output logic          m0_err_o,

  // Master 1
  input  wire logic     m1_cyc_i,
  input  wire logic     m1_stb_i,
  input  wire logic     m1_we_i,
  input  wire wb_addr_t m1_adr_i,
  input  wire wb_data_t m1_dat_i,
  input  wire wb_sel_t  m1_sel_i,
  output wb_data_t      m1_dat_o,
  output logic          m1_stall_o,
  output logic          m1_ack_o,
  output logic          m1_err_o,

  // GPIO pins, split direction
  input  wire gpio_t    gpio_i,
  output gpio_t         gpio_o,
  output gpio_t         gpio_oe_o
);

  arb_state_e grant;
  wb_slave_e  m0_slave, m1_slave;

  wb_if m0_bus ();
  wb_if m1_bus ();
  wb_if ram_bus ();
  wb_if gpio_bus ();

  assign m0_bus.cyc   = m0_cyc_i;
  assign m0_bus.stb   = m0_stb_i;
  assign m0_bus.we    = m0_we_i;
  assign m0_bus.adr   = m0_adr_i;
  assign m0_bus.dat_m = m0_dat_i;
  assign m0_bus.sel   = m0_sel_i;
  assign m0_dat_o     = m0_bus.dat_s;
  assign m0_stall_o   = m0_bus.stall;
  assign m0_ack_o     = m0_bus.ack;
  assign m0_err_o     = m0_bus.err;

  assign m1_bus.cyc   = m1_cyc_i;
  assign m1_bus.stb   = m1_stb_i;
  assign m1_bus.we    = m1_we_i;
  assign m1_bus.adr   = m1_adr_i;
  assign m1_bus.dat_m = m1_dat_i;
  assign m1_bus.sel   = m1_sel_i;
  assign m1_dat_o     = m1_bus.dat_s;
  assign m1_stall_o   = m1_bus.stall;
  assign m1_ack_o     = m1_bus.ack;
  assign m1_err_o     = m1_bus.err;

  wb_arbiter arb_i (
    .sys_clk  (sys_clk),
    .rst_i    (rst_i),
    .m0_cyc_i (m0_cyc_i),
    .m1_cyc_i (m1_cyc_i),
    .grant_o  (grant)
  );

  wb_addr_decoder dec_i (
    .m0_dec     (m0_bus),
    .m1_dec     (m1_bus),
    .m0_slave_o (m0_slave),
    .m1_slave_o (m1_slave)
  );

  wb_shared_bus bus_i (
    .sys_clk    (sys_clk),
    .rst_i      (rst_i),
    .grant_i    (grant),
    .m0_slave_i (m0_slave),
    .m1_slave_i (m1_slave),
    .m0         (m0_bus),
    .m1         (m1_bus),
    .ram        (ram_bus),
    .gpio       (gpio_bus)
  );

  wb_ram_slave #(.DEPTH_WORDS(`SOC_RAM_BYTES / 4)) ram_i (
    .sys_clk (sys_clk),
    .rst_i   (rst_i),
    .bus     (ram_bus)
  );

  wb_gpio_slave #(.WIDTH(`SOC_GPIO_W)) gpio_i0 (
    .sys_clk   (sys_clk),
    .rst_i     (rst_i),
    .bus       (gpio_bus),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o)
  );

endmodule

`default_nettype wire

// ==== sim/soc_fabric_props.sv ====
`default_nettype none

// Protocol properties of the shared bus, seen from the master side
module soc_fabric_props
  import soc_bus_pkg::*;
(
  input wire logic       sys_clk,
  input wire logic       rst_i,
  input wire arb_state_e grant_i,
  input wire logic       accept_i,
  input wire logic       m0_ack_i,
  input wire logic       m0_err_i,
  input wire logic       m1_ack_i,
  input wire logic       m1_err_i
);
  timeunit 1ns;
  timeprecision 100ps;

  logic m0_rsp, m1_rsp;
  int   n_fail = 0;

  assign m0_rsp = m0_ack_i | m0_err_i;
  assign m1_rsp = m1_ack_i | m1_err_i;

  a_ack_err_excl: assert property (@(posedge sys_clk) disable iff (rst_i)
    !(m0_ack_i && m0_err_i) && !(m1_ack_i && m1_err_i))
    else begin
      $error("ack and err high together on one master");
      n_fail++;
    end

  // Responses go to the master that held the grant when the strobe was accepted
  a_m0_granted: assert property (@(posedge sys_clk) disable iff (rst_i)
    m0_rsp |-> $past(grant_i) == ARB_M0)
    else begin
      $error("response to master 0 without grant");
      n_fail++;
    end
  a_m1_granted: assert property (@(posedge sys_clk) disable iff (rst_i)
    m1_rsp |-> $past(grant_i) == ARB_M1)
    else begin
      $error("response to master 1 without grant");
      n_fail++;
    end

  a_rsp_after_accept: assert property (@(posedge sys_clk) disable iff (rst_i)
    (m0_rsp || m1_rsp) |-> $past(accept_i))
    else begin
      $error("response without a strobe");
      n_fail++;
    end
  a_accept_gets_rsp: assert property (@(posedge sys_clk) disable iff (rst_i)
    accept_i |=> (m0_rsp || m1_rsp))
    else begin
      $error("accepted strobe got no response");
      n_fail++;
    end

endmodule

bind wb_shared_bus soc_fabric_props props_i (
  .sys_clk  (sys_clk),
  .rst_i    (rst_i),
  .grant_i  (grant_i),
  .accept_i (accept),
  .m0_ack_i (m0.ack),
  .m0_err_i (m0.err),
  .m1_ack_i (m1.ack),
  .m1_err_i (m1.err)
);

`default_nettype wire

// ==== sim/soc_fabric_tb.sv ====
`default_nettype none

module soc_fabric_tb
  import soc_bus_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 10;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_RECS     = 64;
  localparam int RESP_WAIT    = 8;       // Grant plus response, in cycles

  logic       sys_clk, rst_i;
  logic [1:0] cyc_d, stb_d, we_d;        // Index is the master number
  wb_addr_t   adr_d [2];
  wb_data_t   dat_d [2];
  wb_sel_t    sel_d [2];
  wire  [1:0] stall_w, ack_w, err_w;
  wire wb_data_t m0_dat, m1_dat;
  gpio_t      gpio_in;
  wire gpio_t gpio_out, gpio_oe;

  int         rec_test [MAX_RECS];
  int         rec_mst  [MAX_RECS];
  int         rec_op   [MAX_RECS];
  wb_addr_t   rec_adr  [MAX_RECS];
  wb_data_t   rec_dat  [MAX_RECS];
  wb_sel_t    rec_sel  [MAX_RECS];
  wb_data_t   rec_exp  [MAX_RECS];
  int         n_recs, n_errors, tests_passed, tests_failed;
  logic       loaded;
  wb_master_e last_gnt;                  // Model of the tie-break history

  soc_fabric_top dut_i (
    .sys_clk (sys_clk), .rst_i (rst_i),
    .m0_cyc_i (cyc_d[0]), .m0_stb_i (stb_d[0]), .m0_we_i (we_d[0]),
    .m0_adr_i (adr_d[0]), .m0_dat_i (dat_d[0]), .m0_sel_i (sel_d[0]),
    .m0_dat_o (m0_dat), .m0_stall_o (stall_w[0]), .m0_ack_o (ack_w[0]), .m0_err_o (err_w[0]),
    .m1_cyc_i (cyc_d[1]), .m1_stb_i (stb_d[1]), .m1_we_i (we_d[1]),
    .m1_adr_i (adr_d[1]), .m1_dat_i (dat_d[1]), .m1_sel_i (sel_d[1]),
    .m1_dat_o (m1_dat), .m1_stall_o (stall_w[1]), .m1_ack_o (ack_w[1]), .m1_err_o (err_w[1]),
    .gpio_i (gpio_in), .gpio_o (gpio_out), .gpio_oe_o (gpio_oe)
  );

  initial begin
    sys_clk = 1'b0;
    forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
  end

  task automatic check_data(input string name, input wb_data_t got, input wb_data_t exp_v);
    if (got !== exp_v) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp_v);
      n_errors++;
    end
  endtask

  task automatic check_resp(input string name, input wb_resp_e got, input wb_resp_e exp_v);
    if (got !== exp_v) begin
      $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp_v);
      n_errors++;
    end
  endtask

  task automatic check_gpio(input string name, input gpio_t got, input gpio_t exp_v);
    if (got !== exp_v) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp_v);
      n_errors++;
    end
  endtask

  task automatic check_master(input string name, input wb_master_e got, input wb_master_e exp_v);
    if (got !== exp_v) begin
      $display("Fail at %0t ns: %s is M%0d, expected M%0d", $time, name, got, exp_v);
      n_errors++;
    end
  endtask

  // Own checks plus assertion failures on the shared bus
  function automatic int error_total();
    return n_errors + dut_i.bus_i.props_i.n_fail;
  endfunction

  function automatic wb_data_t read_data(input int m);
    return m ? m1_dat : m0_dat;
  endfunction

  task automatic set_req(input int m, input logic stb, input logic we, input wb_addr_t adr,
                         input wb_data_t dat, input wb_sel_t sel);
    cyc_d[m] = 1'b1;
    stb_d[m] = stb;
    we_d[m]  = we;
    adr_d[m] = adr;
    dat_d[m] = dat;
    sel_d[m] = sel;
  endtask

  // Lines starting with # are column notes
  task automatic load_stimulus();
    int       fd, cnt, t, m, op;
    string    line;
    wb_addr_t adr;
    wb_data_t dat, exp_v;
    wb_sel_t  sel;
    n_recs = 0;
    fd = $fopen("sim/soc_fabric_stimulus.txt", "r");
    if (fd == 0) return;
    while (!$feof(fd) && n_recs < MAX_RECS) begin
      cnt = $fgets(line, fd);
      if (cnt > 1 && line.getc(0) != "#") begin
        cnt = $sscanf(line, "%d %d %d %h %h %h %h", t, m, op, adr, dat, sel, exp_v);
        if (cnt == 7) begin
          rec_test[n_recs] = t;
          rec_mst[n_recs]  = m;
          rec_op[n_recs]   = op;
          rec_adr[n_recs]  = adr;
          rec_dat[n_recs]  = dat;
          rec_sel[n_recs]  = sel;
          rec_exp[n_recs]  = exp_v;
          n_recs++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic single_access(input int m, input logic we, input wb_addr_t adr,
                               input wb_data_t dat, input wb_sel_t sel,
                               output logic got, output wb_resp_e resp, output wb_data_t rdata);
    int   cycles;
    logic accepted;
    cycles   = 0;
    accepted = 1'b0;
    got      = 1'b0;
    resp     = RESP_ACK;
    rdata    = '0;
    set_req(m, 1'b1, we, adr, dat, sel);
    while (!got && cycles < RESP_WAIT) begin
      @(posedge sys_clk);
      cycles++;
      if (accepted && (ack_w[m] || err_w[m])) begin
        got   = 1'b1;
        resp  = err_w[m] ? RESP_ERR : RESP_ACK;
        rdata = read_data(m);
        if (ack_w[m] && err_w[m]) begin
          $display("Master %0d saw ack and err together at %0t ns", m, $time);
          n_errors++;
        end
      end
      if (stb_d[m] && !stall_w[m]) accepted = 1'b1;
      #DRIVE_DELAY;
      if (accepted) stb_d[m] = 1'b0;
    end
    cyc_d[m] = 1'b0;
    @(posedge sys_clk);                   // One idle cycle so the arbiter releases the bus
    #DRIVE_DELAY;
    if (!got) begin
      $display("Master %0d got no response for address %h", m, adr);
      n_errors++;
    end else begin
      last_gnt = wb_master_e'(m);
    end
  endtask

  // Both masters start in the same cycle, one write each
  task automatic contend(input int i);
    int         cycles, k, m, first;
    logic [1:0] accepted, done;
    wb_master_e winner;
    winner   = (last_gnt == M0_M) ? M1_M : M0_M;  // Not granted last wins
    first    = -1;
    accepted = '0;
    done     = '0;
    cycles   = 0;
    for (k = 0; k < 2; k++) begin
      set_req(rec_mst[i+k], 1'b1, 1'b1, rec_adr[i+k], rec_dat[i+k], rec_sel[i+k]);
    end
    while (done != 2'b11 && cycles < 2 * RESP_WAIT) begin
      @(posedge sys_clk);
      cycles++;
      for (m = 0; m < 2; m++) begin
        if (accepted[m] && !done[m] && (ack_w[m] || err_w[m])) begin
          done[m] = 1'b1;
          if (first < 0) first = m;
          check_resp($sformatf("m%0d response", m), err_w[m] ? RESP_ERR : RESP_ACK, RESP_ACK);
        end
        if (cyc_d[m] && stb_d[m] && !stall_w[m]) accepted[m] = 1'b1;
      end
      #DRIVE_DELAY;
      for (m = 0; m < 2; m++) begin
        if (accepted[m]) stb_d[m] = 1'b0;
        if (done[m]) cyc_d[m] = 1'b0;
      end
    end
    cyc_d = '0;
    if (done != 2'b11) begin
      $display("Contention did not complete for both masters");
      n_errors++;
    end else begin
      check_master("first responding master", wb_master_e'(first), winner);
      last_gnt = (winner == M0_M) ? M1_M : M0_M;
    end
  endtask

  task automatic burst_read(input int i, input int n);
    int m, sent, recv, cycles;
    m      = rec_mst[i];
    sent   = 0;
    recv   = 0;
    cycles = 0;
    set_req(m, 1'b1, 1'b0, rec_adr[i], '0, '1);
    while (recv < n && cycles < n + RESP_WAIT) begin
      @(posedge sys_clk);
      cycles++;
      if (ack_w[m] || err_w[m]) begin
        if (recv >= sent) begin
          $display("Master %0d got a response with no strobe in flight", m);
          n_errors++;
        end
        check_resp($sformatf("m%0d response", m), err_w[m] ? RESP_ERR : RESP_ACK, RESP_ACK);
        check_data($sformatf("m%0d_dat_o", m), read_data(m), rec_exp[i+recv]);
        recv++;
      end
      if (stb_d[m] && !stall_w[m]) sent++;
      #DRIVE_DELAY;
      if (sent < n) set_req(m, 1'b1, 1'b0, rec_adr[i+sent], '0, '1);
      else stb_d[m] = 1'b0;
    end
    cyc_d[m] = 1'b0;
    if (recv < n) begin
      $display("Burst on master %0d ended with %0d of %0d responses", m, recv, n);
      n_errors++;
    end
    @(posedge sys_clk);
    if (ack_w[m] || err_w[m]) begin
      $display("Master %0d got an extra response after its burst", m);
      n_errors++;
    end
    #DRIVE_DELAY;
    last_gnt = wb_master_e'(m);
  endtask

  task automatic run_record(inout int idx);
    int       m, j, k;
    logic     got;
    wb_resp_e resp;
    wb_data_t rdata;
    m = rec_mst[idx];
    case (rec_op[idx])
      0: begin
        single_access(m, 1'b1, rec_adr[idx], rec_dat[idx], rec_sel[idx], got, resp, rdata);
        if (got) check_resp($sformatf("m%0d response", m), resp, wb_resp_e'(rec_exp[idx][0]));
        idx++;
      end
      1: begin
        single_access(m, 1'b0, rec_adr[idx], '0, '1, got, resp, rdata);
        if (got) begin
          check_resp($sformatf("m%0d response", m), resp, RESP_ACK);
          check_data($sformatf("m%0d_dat_o", m), rdata, rec_exp[idx]);
        end
        idx++;
      end
      2: begin
        for (k = 0; k < 4; k++) begin
          @(posedge sys_clk);
          if (ack_w != 2'b00 || err_w != 2'b00) begin
            $display("Response seen on an idle bus at %0t ns", $time);
            n_errors++;
          end
          #DRIVE_DELAY;
        end
        check_gpio("gpio_o", gpio_out, gpio_t'(rec_dat[idx]));
        check_gpio("gpio_oe_o", gpio_oe, gpio_t'(rec_exp[idx]));
        idx++;
      end
      3: begin
        gpio_in = gpio_t'(rec_dat[idx]);
        repeat (4) @(posedge sys_clk);          // Covers the two-flop synchronizer
        #DRIVE_DELAY;
        idx++;
      end
      4: begin
        if (idx + 1 < n_recs && rec_op[idx+1] == 4) begin
          contend(idx);
        end else begin
          $display("Contention record %0d has no partner", idx);
          n_errors++;
        end
        idx += 2;
      end
      5: begin
        j = idx;
        while (j < n_recs && rec_op[j] == 5 && rec_test[j] == rec_test[idx]) j++;
        burst_read(idx, j - idx);
        idx = j;
      end
      default: begin
        $display("Unknown operation %0d in record %0d", rec_op[idx], idx);
        n_errors++;
        idx++;
      end
    endcase
  endtask

  initial begin
    loaded = 1'b0;
    wait (loaded);
    repeat ((n_recs + 1) * 40 + RESET_CYCLES) @(posedge sys_clk);
    $display("Timeout: the tests did not finish in the allotted time");
    $display("Result: FAILED");
    $finish;
  end

  initial begin : main_seq
    int i, test, err_before;
    rst_i = 1'b1;
    cyc_d = '0;
    stb_d = '0;
    we_d  = '0;
    for (i = 0; i < 2; i++) begin
      adr_d[i] = '0;
      dat_d[i] = '0;
      sel_d[i] = '0;
    end
    gpio_in      = '0;
    n_errors     = 0;
    tests_passed = 0;
    tests_failed = 0;
    last_gnt     = M0_M;                  // Reset value of the tie history
    load_stimulus();
    loaded = 1'b1;
    if (n_recs == 0) begin
      $display("Stimulus file could not be read or holds no records");
      n_errors++;
    end
    repeat (RESET_CYCLES) @(posedge sys_clk);
    #DRIVE_DELAY;
    rst_i = 1'b0;
    i = 0;
    while (i < n_recs) begin
      test       = rec_test[i];
      err_before = error_total();
      while (i < n_recs && rec_test[i] == test) run_record(i);
      if (error_total() == err_before) begin
        tests_passed++;
        $display("Test %0d finished: passed", test);
      end else begin
        tests_failed++;
        $display("Test %0d finished: %0d errors", test, error_total() - err_before);
      end
    end
    $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (error_total() == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
verilog/soc_bus_pkg.sv
verilog/wb_if.sv
verilog/wb_arbiter.sv
verilog/wb_addr_decoder.sv
verilog/wb_shared_bus.sv
verilog/wb_ram_slave.sv
verilog/wb_gpio_slave.sv
verilog/soc_fabric_top.sv
sim/soc_fabric_props.sv
sim/soc_fabric_tb.sv

// ==== sim/soc_fabric_stimulus.txt ====
# test master op address data sel expected; test and op decimal, the rest hex
# op 0 write (expected 0 ack, 1 err), 1 read, 2 pins (data gpio_o, expected gpio_oe_o),
# op 3 drive gpio_i, 4 two-master contention pair, 5 back-to-back read burst
1 0 2 00000000 00000000 0 00000000
2 0 0 00000010 11223344 f 00000000
2 0 0 00000010 aabbccdd 5 00000000
2 1 1 00000010 00000000 0 11bb33dd
3 0 0 10000000 000000a5 1 00000000
3 1 0 10000004 0000000f 1 00000000
3 0 2 00000000 000000a5 0 0000000f
3 0 3 00000000 0000003c 0 00000000
3 1 1 10000008 00000000 0 0000003c
3 0 1 10000000 00000000 0 000000a5
4 1 0 00000400 12345678 f 00000001
4 0 0 20000000 deadbeef f 00000001
4 0 1 00000010 00000000 0 11bb33dd
5 0 4 00000100 01010101 f 00000000
5 1 4 00000104 02020202 f 00000000
5 0 1 00000100 00000000 0 01010101
5 1 1 00000104 00000000 0 02020202
6 1 0 00000200 cafef00d f 00000000
6 0 5 00000010 00000000 0 11bb33dd
6 0 5 00000100 00000000 0 01010101
6 0 5 00000104 00000000 0 02020202
6 0 5 00000200 00000000 0 cafef00d
